// ==== hw/feat_addr_encoder.sv ====
/*
 * Feature address encoder
 * One-entry pipeline stage, tile coordinate in, full-word base
 * address of the tile's feature vector out
 */
`timescale 1ns/10ps
`default_nettype none

`include "nb_fetch_macros.svh"

module feat_addr_encoder (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    en,
  input  logic                    req_valid,
  output logic                    req_ready,
  input  nb_fetch_pkg::tile_row_t req_row,
  input  nb_fetch_pkg::tile_col_t req_col,
  input  nb_fetch_pkg::tag_t      req_tag,
  output logic                    cmd_valid,
  input  logic                    cmd_ready,
  output nb_fetch_pkg::word_addr_t cmd_addr,
  output nb_fetch_pkg::tag_t      cmd_tag
);
  import nb_fetch_pkg::*;

  word_addr_t tile_lin;
  word_addr_t base_addr;
  logic       req_fire;
  logic       cmd_fire;

  // Linear tile index, row-major over the grid
  assign tile_lin  = word_addr_t'(req_row) * word_addr_t'(`NB_TILES_X) + word_addr_t'(req_col);
  // Each tile owns NB_BEATS consecutive words
  assign base_addr = word_addr_t'(`NB_BASE_ADDR) + tile_lin * word_addr_t'(`NB_BEATS);

  // Take a new request when empty or draining this cycle
  assign req_ready = !cmd_valid || cmd_ready;
  assign req_fire  = en && req_valid && req_ready;
  assign cmd_fire  = en && cmd_valid && cmd_ready;

  // --------------------
  // Valid flag
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_valid <= 1'b0;
    end else if (req_fire) begin
      cmd_valid <= 1'b1;
    end else if (cmd_fire) begin
      cmd_valid <= 1'b0;
    end
  end

  // Payload, tag passes through unchanged
  always_ff @(posedge clk) begin
    if (req_fire) begin
      cmd_addr <= base_addr;
      cmd_tag  <= req_tag;
    end
  end

endmodule

`default_nettype wire

// ==== hw/feat_burst_reader.sv ====
/*
 * Feature burst reader
 * Issues one SRAM read per memory word of a feature vector and
 * packs the in-order returns into one vector, beat 0 lowest
 */
`timescale 1ns/10ps
`default_nettype none

`include "nb_fetch_macros.svh"

module feat_burst_reader (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     en,
  input  logic                     cmd_valid,
  output logic                     cmd_ready,
  input  nb_fetch_pkg::word_addr_t cmd_addr,
  input  nb_fetch_pkg::tag_t       cmd_tag,
  output logic                     mem_rd_valid,
  input  logic                     mem_rd_ready,
  output nb_fetch_pkg::word_addr_t mem_rd_addr,
  input  logic                     mem_rvalid,
  input  nb_fetch_pkg::mem_word_t  mem_rdata,
  output logic                     feat_valid,
  input  logic                     feat_ready,
  output nb_fetch_pkg::feat_vec_t  feat_vec,
  output nb_fetch_pkg::tag_t       feat_tag
);
  import nb_fetch_pkg::*;

  localparam beat_t NUM_BEATS = beat_t'(`NB_BEATS);
  localparam beat_t LAST_BEAT = beat_t'(`NB_BEATS - 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_HOLD
  } state_t;

  state_t     state;
  // Beats issued and beats returned
  beat_t      iss_cnt;
  beat_t      ret_cnt;
  word_addr_t base_q;
  tag_t       tag_q;
  feat_vec_t  vec_q;
  logic       cmd_fire;
  logic       rd_fire;
  logic       feat_fire;
  logic       ret_take;

  // --------------------
  // Handshakes
  // --------------------
  // One burst at a time
  assign cmd_ready    = (state == S_IDLE);
  assign mem_rd_valid = (state == S_READ) && (iss_cnt != NUM_BEATS);
  assign mem_rd_addr  = base_q + word_addr_t'(iss_cnt);
  assign feat_valid   = (state == S_HOLD);
  assign feat_vec     = vec_q;
  assign feat_tag     = tag_q;

  assign cmd_fire  = en && cmd_valid && cmd_ready;
  assign rd_fire   = en && mem_rd_valid && mem_rd_ready;
  assign feat_fire = en && feat_valid && feat_ready;
  // The SRAM return has no ready, so a word is taken even while frozen
  assign ret_take  = mem_rvalid && (state == S_READ);

  // --------------------
  // Control
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= S_IDLE;
      iss_cnt <= '0;
      ret_cnt <= '0;
    end else begin
      if (en) begin
        case (state)
          S_IDLE: begin
            if (cmd_fire) begin
              state   <= S_READ;
              iss_cnt <= '0;
              ret_cnt <= '0;
            end
          end
          S_HOLD: begin
            // Vector consumed, ready for the next command
            if (feat_fire)
              state <= S_IDLE;
          end
          default: begin
          end
        endcase
        if (rd_fire)
          iss_cnt <= iss_cnt + 1'b1;
      end
      // Last return makes the vector valid in the next cycle
      if (ret_take) begin
        if (ret_cnt == LAST_BEAT) begin
          ret_cnt <= '0;
          state   <= S_HOLD;
        end else begin
          ret_cnt <= ret_cnt + 1'b1;
        end
      end
    end
  end

  // --------------------
  // Payload
  // --------------------
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      base_q <= cmd_addr;
      tag_q  <= cmd_tag;
    end
    // Shift in from the top, beat 0 ends up lowest
    if (ret_take)
      vec_q <= {mem_rdata, vec_q[`NB_FEAT_W-1:`NB_MEM_W]};
  end

endmodule

`default_nettype wire

// ==== hw/nb_3x3_scheduler.sv ====
/*
 * 3x3 neighborhood scheduler
 * Takes one center tile and emits its nine neighbor requests in
 * row-major order, clamped at the grid edges
 */
`timescale 1ns/10ps
`default_nettype none

`include "nb_fetch_macros.svh"

module nb_3x3_scheduler (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   en,
  input  logic                   center_valid,
  output logic                   center_ready,
  input  nb_fetch_pkg::tile_row_t center_row,
  input  nb_fetch_pkg::tile_col_t center_col,
  input  nb_fetch_pkg::ctag_t    center_tag,
  output logic                   req_valid,
  input  logic                   req_ready,
  output nb_fetch_pkg::tile_row_t req_row,
  output nb_fetch_pkg::tile_col_t req_col,
  output nb_fetch_pkg::tag_t     req_tag,
  output logic                   sched_busy,
  output logic [8:0]             nb_is_center
);
  import nb_fetch_pkg::*;

  localparam int unsigned IDX_W   = `NB_TAG_W - `NB_CTAG_W;
  localparam int unsigned LAST_NB = 8;

  // Offset code 0, 1, 2 means -1, 0, +1
  function automatic tile_row_t clamp_row(input tile_row_t r, input logic [1:0] off);
    tile_row_t res;
    res = r;
    if (off == 2'd0 && r != '0)
      res = r - 1'b1;
    else if (off == 2'd2 && r != tile_row_t'(`NB_TILES_Y - 1))
      res = r + 1'b1;
    return res;
  endfunction

  function automatic tile_col_t clamp_col(input tile_col_t c, input logic [1:0] off);
    tile_col_t res;
    res = c;
    if (off == 2'd0 && c != '0)
      res = c - 1'b1;
    else if (off == 2'd2 && c != tile_col_t'(`NB_TILES_X - 1))
      res = c + 1'b1;
    return res;
  endfunction

  logic             busy;
  logic [IDX_W-1:0] nb_idx;
  tile_row_t        row_q;
  tile_col_t        col_q;
  ctag_t            ctag_q;
  logic             center_fire;
  logic             req_fire;
  logic [8:0]       is_center_d;

  // --------------------
  // Handshakes
  // --------------------
  assign center_ready = !busy;
  assign center_fire  = en && center_valid && center_ready;
  assign req_valid    = busy;
  assign req_fire     = en && req_valid && req_ready;
  assign sched_busy   = busy;

  // Neighbor k sits at row offset k/3, column offset k%3
  assign req_row = clamp_row(row_q, 2'(nb_idx / 3));
  assign req_col = clamp_col(col_q, 2'(nb_idx % 3));
  assign req_tag = {ctag_q, nb_idx};

  // Neighbors that clamp back onto the center, taken from the live inputs
  always_comb begin
    for (int k = 0; k < 9; k++) begin
      is_center_d[k] = (clamp_row(center_row, 2'(k / 3)) == center_row) &&
                       (clamp_col(center_col, 2'(k % 3)) == center_col);
    end
  end

  // --------------------
  // Control
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      busy         <= 1'b0;
      nb_idx       <= '0;
      nb_is_center <= '0;
    end else if (en) begin
      if (center_fire) begin
        busy         <= 1'b1;
        nb_idx       <= '0;
        nb_is_center <= is_center_d;
      end else if (req_fire) begin
        // Ninth request ends the expansion
        if (nb_idx == IDX_W'(LAST_NB))
          busy <= 1'b0;
        else
          nb_idx <= nb_idx + 1'b1;
      end
    end
  end

  // Center latch
  always_ff @(posedge clk) begin
    if (center_fire) begin
      row_q  <= center_row;
      col_q  <= center_col;
      ctag_q <= center_tag;
    end
  end

endmodule

`default_nettype wire

// ==== hw/nb_feature_fetch_top.sv ====
/*
 * Neighborhood feature fetch top
 * Scheduler, address encoder and burst reader in one chain, with
 * the SRAM bank split and the end-to-end done pulse
 */
`timescale 1ns/10ps
`default_nettype none

`include "nb_fetch_macros.svh"

module nb_feature_fetch_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     en,
  input  logic                     center_valid,
  output logic                     center_ready,
  input  nb_fetch_pkg::tile_row_t  center_row,
  input  nb_fetch_pkg::tile_col_t  center_col,
  input  nb_fetch_pkg::ctag_t      center_tag,
  output logic                     mem_rd_valid,
  input  logic                     mem_rd_ready,
  output logic [`NB_BANK_W-1:0]    mem_bank,
  output logic [`NB_ADDR_W-1:0]    mem_addr,
  input  logic                     mem_rvalid,
  input  nb_fetch_pkg::mem_word_t  mem_rdata,
  output logic                     feat_valid,
  input  logic                     feat_ready,
  output nb_fetch_pkg::feat_vec_t  feat_vec,
  output nb_fetch_pkg::tag_t       feat_tag,
  output logic                     sched_busy,
  output logic                     sched_done_pulse,
  output logic [8:0]               nb_is_center
);
  import nb_fetch_pkg::*;

  // Scheduler to encoder
  logic       req_valid;
  logic       req_ready;
  tile_row_t  req_row;
  tile_col_t  req_col;
  tag_t       req_tag;
  // Encoder to reader
  logic       cmd_valid;
  logic       cmd_ready;
  word_addr_t cmd_addr;
  tag_t       cmd_tag;
  // Reader to SRAM, before the bank split
  logic       rd_valid_full;
  word_addr_t rd_addr_full;
  // End-to-end tracking
  logic       sched_center_ready;
  logic       e2e_busy;
  logic [3:0] feat_cnt;
  logic       center_fire;
  logic       feat_fire;

  // --------------------
  // Center gating
  // --------------------
  // No new center until the ninth feature of the last one is consumed
  assign center_ready = sched_center_ready && !e2e_busy;
  assign center_fire  = en && center_valid && center_ready;
  assign feat_fire    = en && feat_valid && feat_ready;

  nb_3x3_scheduler i_sched (
    .clk          (clk),
    .rst          (rst),
    .en           (en),
    .center_valid (center_valid && !e2e_busy),
    .center_ready (sched_center_ready),
    .center_row   (center_row),
    .center_col   (center_col),
    .center_tag   (center_tag),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .req_row      (req_row),
    .req_col      (req_col),
    .req_tag      (req_tag),
    .sched_busy   (sched_busy),
    .nb_is_center (nb_is_center)
  );

  feat_addr_encoder i_enc (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_row   (req_row),
    .req_col   (req_col),
    .req_tag   (req_tag),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_addr  (cmd_addr),
    .cmd_tag   (cmd_tag)
  );

  feat_burst_reader i_reader (
    .clk          (clk),
    .rst          (rst),
    .en           (en),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .cmd_addr     (cmd_addr),
    .cmd_tag      (cmd_tag),
    .mem_rd_valid (rd_valid_full),
    .mem_rd_ready (mem_rd_ready),
    .mem_rd_addr  (rd_addr_full),
    .mem_rvalid   (mem_rvalid),
    .mem_rdata    (mem_rdata),
    .feat_valid   (feat_valid),
    .feat_ready   (feat_ready),
    .feat_vec     (feat_vec),
    .feat_tag     (feat_tag)
  );

  // --------------------
  // Bank split
  // --------------------
  // Held back while frozen so the SRAM takes no read the reader misses
  assign mem_rd_valid = rd_valid_full && en;
  // Low bits pick the bank, the rest is the in-bank word
  assign mem_bank     = rd_addr_full[`NB_BANK_W-1:0];
  assign mem_addr     = rd_addr_full >> `NB_BANK_W;

  // --------------------
  // End-to-end done
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      e2e_busy <= 1'b0;
      feat_cnt <= '0;
    end else if (center_fire) begin
      e2e_busy <= 1'b1;
      feat_cnt <= '0;
    end else if (e2e_busy && feat_fire) begin
      // Counts consumed features 0..8
      if (feat_cnt == 4'd8) begin
        e2e_busy <= 1'b0;
        feat_cnt <= '0;
      end else begin
        feat_cnt <= feat_cnt + 1'b1;
      end
    end
  end

  // Pulse in the cycle the ninth feature fires
  assign sched_done_pulse = e2e_busy && feat_fire && (feat_cnt == 4'd8);

endmodule

`default_nettype wire

// ==== hw/nb_fetch_macros.svh ====
/*
 * Neighborhood feature fetch configuration
 * Tile grid, tag layout, memory geometry and read latency
 */
`ifndef NB_FETCH_MACROS_SVH
`define NB_FETCH_MACROS_SVH

// Tile grid
`define NB_TILES_X 20
`define NB_TILES_Y 12

// Tags: upper bits center tag, lower bits neighbor index 0..8
`define NB_CTAG_W 4
`define NB_TAG_W 8

// Feature vector and memory word
`define NB_FEAT_W 256
`define NB_MEM_W 64
`define NB_BEATS (`NB_FEAT_W / `NB_MEM_W)

// Banks, must be a power of two
`define NB_BANKS 2
`define NB_BANK_W ((`NB_BANKS <= 1) ? 1 : $clog2(`NB_BANKS))
`define NB_ADDR_W 16
`define NB_BASE_ADDR 0
`define NB_READ_LATENCY 1

`endif

// ==== hw/nb_fetch_pkg.sv ====
/*
 * Shared types of the neighborhood feature fetch
 * Tile coordinates, tags, word addresses and data words
 */
`default_nettype none

`include "nb_fetch_macros.svh"

package nb_fetch_pkg;

  // --------------------
  // Tile coordinates
  // --------------------
  typedef logic [$clog2(`NB_TILES_Y)-1:0] tile_row_t;
  typedef logic [$clog2(`NB_TILES_X)-1:0] tile_col_t;

  // --------------------
  // Tags
  // --------------------
  typedef logic [`NB_CTAG_W-1:0] ctag_t;
  // {center tag, neighbor index}
  typedef logic [`NB_TAG_W-1:0] tag_t;

  // --------------------
  // Memory side
  // --------------------
  // Full-word address, before the bank split
  typedef logic [`NB_ADDR_W-1:0] word_addr_t;
  typedef logic [`NB_MEM_W-1:0] mem_word_t;
  // Beat 0 in the least significant word
  typedef logic [`NB_FEAT_W-1:0] feat_vec_t;
  // Counts 0..NB_BEATS inclusive
  typedef logic [$clog2(`NB_BEATS + 1)-1:0] beat_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the neighborhood feature fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module tb_nb_feature_fetch \
  -f sim.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed!" sim.log; then
  exit 0
fi
exit 1

// ==== sim.f ====
+incdir+hw
hw/nb_fetch_pkg.sv
hw/nb_3x3_scheduler.sv
hw/feat_addr_encoder.sv
hw/feat_burst_reader.sv
hw/nb_feature_fetch_top.sv
sim/feat_sram_model.sv
sim/tb_nb_feature_fetch.sv

// ==== sim/feat_sram_model.sv ====
/*
 * Banked feature SRAM model
 * Fixed read latency, in-order returns, stall input that drops
 * mem_rd_ready, and a write port used to preload the contents
 */
`timescale 1ns/10ps
`default_nettype none

`include "nb_fetch_macros.svh"

module feat_sram_model (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wr_en,
  input  logic [`NB_BANK_W-1:0]   wr_bank,
  input  logic [`NB_ADDR_W-1:0]   wr_addr,
  input  nb_fetch_pkg::mem_word_t wr_data,
  input  logic                    stall,
  input  logic                    mem_rd_valid,
  output logic                    mem_rd_ready,
  input  logic [`NB_BANK_W-1:0]   mem_bank,
  input  logic [`NB_ADDR_W-1:0]   mem_addr,
  output logic                    mem_rvalid,
  output nb_fetch_pkg::mem_word_t mem_rdata
);
  import nb_fetch_pkg::*;

  localparam int LAT   = `NB_READ_LATENCY;
  // Words per bank for the whole tile grid
  localparam int DEPTH = `NB_TILES_X * `NB_TILES_Y * `NB_BEATS / `NB_BANKS;

  mem_word_t bank_mem [`NB_BANKS][DEPTH];
  logic      vld_pipe [LAT];
  mem_word_t dat_pipe [LAT];

  assign mem_rd_ready = !stall;
  assign mem_rvalid   = vld_pipe[LAT-1];
  assign mem_rdata    = dat_pipe[LAT-1];

  // Read pipeline, one stage per cycle of latency
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < LAT; i++)
        vld_pipe[i] <= 1'b0;
    end else begin
      vld_pipe[0] <= mem_rd_valid && mem_rd_ready;
      dat_pipe[0] <= bank_mem[mem_bank][mem_addr];
      for (int i = 1; i < LAT; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
        dat_pipe[i] <= dat_pipe[i-1];
      end
    end
    // Preload port
    if (wr_en)
      bank_mem[wr_bank][wr_addr] <= wr_data;
  end

endmodule

`default_nettype wire

// ==== sim/tb_nb_feature_fetch.sv ====
/*
 * Testbench for the neighborhood feature fetch
 * Directed tests against a reference model of the 3x3 expansion,
 * the address rule and the bank split, with LFSR data and stalls
 */
`timescale 1ns/10ps
`default_nettype none

`include "nb_fetch_macros.svh"

module tb_nb_feature_fetch;
  import nb_fetch_pkg::*;

  localparam int TX     = `NB_TILES_X;
  localparam int TY     = `NB_TILES_Y;
  localparam int BEATS  = `NB_BEATS;
  localparam int MEM_W  = `NB_MEM_W;
  localparam int BANK_W = `NB_BANK_W;
  localparam int IDX_W  = `NB_TAG_W - `NB_CTAG_W;
  localparam int DEPTH  = TX * TY * BEATS;
  localparam int TMO    = 5000;

  logic clk;
  logic rst;
  logic en;
  logic center_valid;
  logic center_ready;
  tile_row_t center_row;
  tile_col_t center_col;
  ctag_t center_tag;
  logic mem_rd_valid;
  logic mem_rd_ready;
  logic [BANK_W-1:0] mem_bank;
  logic [`NB_ADDR_W-1:0] mem_addr;
  logic mem_rvalid;
  mem_word_t mem_rdata;
  logic feat_valid;
  logic feat_ready;
  feat_vec_t feat_vec;
  tag_t feat_tag;
  logic sched_busy;
  logic sched_done_pulse;
  logic [8:0] nb_is_center;
  // SRAM preload and stall control
  logic wr_en;
  logic [BANK_W-1:0] wr_bank;
  logic [`NB_ADDR_W-1:0] wr_addr;
  mem_word_t wr_data;
  logic mem_stall;
  logic stall_mode;
  logic rand_ready;
  logic rand_stall;
  logic feat_ready_man;

  // Reference state
  logic [31:0] lfsr_q;
  mem_word_t mirror [DEPTH];
  int exp_addr [$];
  tag_t exp_tag [$];
  feat_vec_t exp_vec [$];
  tag_t got_tag [$];
  feat_vec_t got_vec [$];
  logic in_flight;
  int fcount;
  int done_cnt;
  int value_errs;
  int other_errs;
  logic pulse_exp;
  int a_exp;

  nb_feature_fetch_top i_dut (
    .clk(clk), .rst(rst), .en(en),
    .center_valid(center_valid), .center_ready(center_ready),
    .center_row(center_row), .center_col(center_col), .center_tag(center_tag),
    .mem_rd_valid(mem_rd_valid), .mem_rd_ready(mem_rd_ready),
    .mem_bank(mem_bank), .mem_addr(mem_addr),
    .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
    .feat_valid(feat_valid), .feat_ready(feat_ready),
    .feat_vec(feat_vec), .feat_tag(feat_tag),
    .sched_busy(sched_busy), .sched_done_pulse(sched_done_pulse),
    .nb_is_center(nb_is_center)
  );

  feat_sram_model i_sram (
    .clk(clk), .rst(rst),
    .wr_en(wr_en), .wr_bank(wr_bank), .wr_addr(wr_addr), .wr_data(wr_data),
    .stall(mem_stall),
    .mem_rd_valid(mem_rd_valid), .mem_rd_ready(mem_rd_ready),
    .mem_bank(mem_bank), .mem_addr(mem_addr),
    .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata)
  );

  // Random back-pressure only in stall mode
  assign feat_ready = stall_mode ? rand_ready : feat_ready_man;
  assign mem_stall  = stall_mode && rand_stall;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------
  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic int clamp(input int v, input int max_v);
    if (v < 0)
      return 0;
    if (v > max_v)
      return max_v;
    return v;
  endfunction

  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
    assert (got === exp) else begin
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
      value_errs++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    other_errs++;
  endtask

  // New stall bits each falling edge
  always @(negedge clk) begin
    if (stall_mode) begin
      rand_ready = take_bits(1) != 0;
      rand_stall = take_bits(1) != 0;
    end
  end

  // --------------------
  // Monitor
  // --------------------
  // Sampled at the rising edge before any register updates
  always @(posedge clk) begin
    if (rst) begin
      in_flight = 1'b0;
      fcount = 0;
    end else begin
      check_value("center_ready", center_ready, !in_flight);
      if (en && mem_rd_valid && mem_rd_ready) begin
        assert (exp_addr.size() != 0) else begin
          $display("SRAM read at %0t ns when no read was expected", $time);
          other_errs++;
        end
        if (exp_addr.size() != 0) begin
          a_exp = exp_addr.pop_front();
          check_value("mem_bank", mem_bank, a_exp % (1 << BANK_W));
          check_value("mem_addr", mem_addr, a_exp >> BANK_W);
        end
      end
      pulse_exp = 1'b0;
      if (en && feat_valid && feat_ready) begin
        got_tag.push_back(feat_tag);
        got_vec.push_back(feat_vec);
        fcount++;
        pulse_exp = (fcount == 9);
      end
      check_value("sched_done_pulse", sched_done_pulse, pulse_exp);
      // Pulses seen on the DUT port
      if (sched_done_pulse)
        done_cnt++;
      if (pulse_exp) begin
        in_flight = 1'b0;
        fcount = 0;
      end
      if (en && center_valid && center_ready) begin
        in_flight = 1'b1;
        fcount = 0;
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  task automatic fill_memory();
    for (int a = 0; a < DEPTH; a++) begin
      mirror[a] = take_bits(MEM_W);
      wr_en = 1'b1;
      wr_bank = BANK_W'(a % (1 << BANK_W));
      wr_addr = `NB_ADDR_W'(a >> BANK_W);
      wr_data = mirror[a];
      @(negedge clk);
    end
    wr_en = 1'b0;
  endtask

  // Queue the expected reads and features, then hand the center over
  task automatic start_center(input int r, input int c, input int ct);
    int t;
    int nr;
    int nc;
    int base;
    logic [8:0] mask;
    feat_vec_t v;
    mask = '0;
    for (int k = 0; k < 9; k++) begin
      nr = clamp(r + k / 3 - 1, TY - 1);
      nc = clamp(c + k % 3 - 1, TX - 1);
      base = `NB_BASE_ADDR + (nr * TX + nc) * BEATS;
      v = '0;
      for (int b = 0; b < BEATS; b++) begin
        exp_addr.push_back(base + b);
        v[b*MEM_W +: MEM_W] = mirror[base + b];
      end
      exp_tag.push_back(tag_t'((ct << IDX_W) | k));
      exp_vec.push_back(v);
      mask[k] = (nr == r) && (nc == c);
    end
    center_row = tile_row_t'(r);
    center_col = tile_col_t'(c);
    center_tag = ctag_t'(ct);
    center_valid = 1'b1;
    t = 0;
    while (!center_ready && t < TMO) begin
      @(negedge clk);
      t++;
    end
    assert (center_ready) else report_timeout("center_ready");
    @(negedge clk);
    center_valid = 1'b0;
    check_value("nb_is_center", nb_is_center, mask);
  endtask

  // Wait for n features, compare them in order, then look for strays
  task automatic collect_features(input int n, input int d0);
    int t;
    t = 0;
    while (got_tag.size() < n && t < TMO) begin
      @(negedge clk);
      t++;
    end
    assert (got_tag.size() >= n) else report_timeout("feature vectors");
    for (int i = 0; i < n && i < got_tag.size(); i++) begin
      check_value("feat_tag", got_tag[i], exp_tag[i]);
      check_value("feat_vec", got_vec[i], exp_vec[i]);
    end
    repeat (20) @(negedge clk);
    check_value("feature count", got_tag.size(), n);
    check_value("pending SRAM reads", exp_addr.size(), 0);
    check_value("done pulse count", done_cnt - d0, n / 9);
    got_tag.delete();
    got_vec.delete();
    exp_tag.delete();
    exp_vec.delete();
    exp_addr.delete();
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_reset_state();
    check_value("mem_rd_valid", mem_rd_valid, 1'b0);
    check_value("feat_valid", feat_valid, 1'b0);
    check_value("sched_done_pulse", sched_done_pulse, 1'b0);
    check_value("sched_busy", sched_busy, 1'b0);
    check_value("center_ready", center_ready, 1'b1);
  endtask

  task automatic test_interior();
    int d0;
    d0 = done_cnt;
    start_center(5, 10, 3);
    // Only the center itself
    check_value("nb_is_center", nb_is_center, 9'b0_0001_0000);
    collect_features(9, d0);
  endtask

  task automatic test_corners();
    int d0;
    d0 = done_cnt;
    start_center(0, 0, 1);
    collect_features(9, d0);
    d0 = done_cnt;
    start_center(TY - 1, TX - 1, 2);
    collect_features(9, d0);
  endtask

  task automatic test_stalls();
    int d0;
    d0 = done_cnt;
    stall_mode = 1'b1;
    start_center(6, 3, 4);
    start_center(0, TX - 1, 5);
    collect_features(18, d0);
    stall_mode = 1'b0;
  endtask

  // Second center waits for the ninth feature of the first
  task automatic test_back_to_back();
    int d0;
    d0 = done_cnt;
    start_center(3, 0, 7);
    start_center(TY - 1, 8, 8);
    collect_features(18, d0);
  endtask

  task automatic test_freeze();
    int d0;
    int t;
    tag_t s_tag;
    feat_vec_t s_vec;
    logic s_busy;
    d0 = done_cnt;
    feat_ready_man = 1'b0;
    start_center(7, 12, 6);
    t = 0;
    while (!feat_valid && t < TMO) begin
      @(negedge clk);
      t++;
    end
    assert (feat_valid) else report_timeout("feat_valid");
    // Freeze with a vector waiting, then offer to take it
    en = 1'b0;
    feat_ready_man = 1'b1;
    s_tag = feat_tag;
    s_vec = feat_vec;
    s_busy = sched_busy;
    repeat (10) begin
      @(negedge clk);
      check_value("feat_valid", feat_valid, 1'b1);
      check_value("feat_tag", feat_tag, s_tag);
      check_value("feat_vec", feat_vec, s_vec);
      check_value("sched_busy", sched_busy, s_busy);
      check_value("mem_rd_valid", mem_rd_valid, 1'b0);
      check_value("center_ready", center_ready, 1'b0);
    end
    en = 1'b1;
    collect_features(9, d0);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    lfsr_q = 32'd84708;
    rst = 1'b1;
    en = 1'b1;
    center_valid = 1'b0;
    center_row = '0;
    center_col = '0;
    center_tag = '0;
    wr_en = 1'b0;
    wr_bank = '0;
    wr_addr = '0;
    wr_data = '0;
    stall_mode = 1'b0;
    rand_ready = 1'b1;
    rand_stall = 1'b0;
    feat_ready_man = 1'b1;
    done_cnt = 0;
    value_errs = 0;
    other_errs = 0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    test_reset_state();
    fill_memory();
    test_interior();
    test_corners();
    test_stalls();
    test_back_to_back();
    test_freeze();
    $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
